//--- filelist.f
fmSynthPkg.sv
fmRegBank.sv
fmChannelScheduler.sv
fmWaveShaper.sv
fmOperatorPair.sv
fmMixer.sv
fmSynthTop.sv
fmSynthTb.sv

//--- fmChannelScheduler.sv
`timescale 1ns/10ps

module fmChannelScheduler (
	input logic clock,
	input logic reset,
	input logic channelTick,
	input logic sampleTick,
	output fmSynthPkg::fmTag_t tag,
	output logic stepFrame,
	output logic frameEnd
);

	logic tickQ;
	logic sampleQ;
	logic stepLatch;
	fmSynthPkg::fmChannel_t rover;
	logic roverWrap;

	assign roverWrap = tickQ && (rover == fmSynthPkg::fmLastChannel);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			tickQ <= 1'b0;
			sampleQ <= 1'b0;
			stepLatch <= 1'b0;
			rover <= '0;
			tag <= '0;
			stepFrame <= 1'b0;
			frameEnd <= 1'b0;
		end
		else
		begin
			tickQ <= channelTick;
			sampleQ <= sampleTick;

			// one tag per tick, for the channel the rover moves to
			tag.valid <= tickQ;
			frameEnd <= roverWrap;
			if (tickQ)
			begin
				rover <= rover + 1'b1;
				tag.channel <= rover + 1'b1;
			end

			// step request waits for the frame boundary
			if (roverWrap)
			begin
				stepFrame <= stepLatch;
				stepLatch <= sampleQ;
			end
			else if (sampleQ)
				stepLatch <= 1'b1;
		end
	end

endmodule

//--- fmMixer.sv
`timescale 1ns/10ps

module fmMixer (
	input logic clock,
	input logic reset,
	input fmSynthPkg::fmSample_t channelSample,
	input fmSynthPkg::fmTag_t sampleTag,
	input logic frameEnd,
	output fmSynthPkg::fmSample_t pcmLeft,
	output fmSynthPkg::fmSample_t pcmRight
);

	fmSynthPkg::fmAccum_t accum;
	fmSynthPkg::fmAccum_t addend;
	fmSynthPkg::fmSample_t saturated;

	always_comb
	begin
		addend = '0;
		if (sampleTag.valid)
			addend = {{4{channelSample[7]}}, channelSample};

		// clip when the upper bits are not a sign extension
		saturated = accum[7:0];
		if (accum[11:8] != {4{accum[7]}})
			saturated = accum[11] ? 8'sh80 : 8'sh7F;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			accum <= '0;
			pcmLeft <= '0;
			pcmRight <= '0;
		end
		else if (frameEnd)
		begin
			// mono mix on both sides
			pcmLeft <= saturated;
			pcmRight <= saturated;
			// a sample landing on the boundary opens the next frame
			accum <= addend;
		end
		else
			accum <= accum + addend;
	end

endmodule

//--- fmOperatorPair.sv
`timescale 1ns/10ps

module fmOperatorPair (
	input logic clock,
	input logic reset,
	input fmSynthPkg::fmChanState_t chanState,
	input fmSynthPkg::fmTag_t stateTag,
	output fmSynthPkg::fmSample_t channelSample,
	output fmSynthPkg::fmTag_t sampleTag
);

	localparam int depth = fmSynthPkg::fmShaperDepth;

	fmSynthPkg::fmSample_t modSample;
	fmSynthPkg::fmSample_t carSample;
	fmSynthPkg::fmPhase_t carPhaseDly [depth];
	fmSynthPkg::fmCtrlWord_t carCtrlDly [depth];
	fmSynthPkg::fmSample_t modSampleDly [depth];
	logic modEnableDly [depth];
	fmSynthPkg::fmTag_t tagDly [2 * depth];
	fmSynthPkg::fmPhase_t carPhase;
	fmSynthPkg::fmCtrlWord_t carCtrl;

	// operator B modulates
	fmWaveShaper modShaper_i (
		.clock(clock),
		.reset(reset),
		.phase(chanState.phaseB),
		.ctrl(chanState.ctrlB),
		.sample(modSample)
	);

	assign carCtrl = carCtrlDly[depth - 1];

	// modulator output bits 7:2 offset the carrier table index
	always_comb
	begin
		carPhase = carPhaseDly[depth - 1];
		if (carCtrl.modEnable)
			carPhase = carPhase + (fmSynthPkg::fmPhase_t'(modSample[7:2]) << fmSynthPkg::fmModBit);
	end

	// operator A is the carrier
	fmWaveShaper carShaper_i (
		.clock(clock),
		.reset(reset),
		.phase(carPhase),
		.ctrl(carCtrl),
		.sample(carSample)
	);

	always_ff @(posedge clock)
	begin
		carPhaseDly[0] <= chanState.phaseA;
		carCtrlDly[0] <= chanState.ctrlA;
		modSampleDly[0] <= modSample;
		modEnableDly[0] <= carCtrl.modEnable;
		for (int i = 1; i < depth; i++)
		begin
			carPhaseDly[i] <= carPhaseDly[i - 1];
			carCtrlDly[i] <= carCtrlDly[i - 1];
			modSampleDly[i] <= modSampleDly[i - 1];
			modEnableDly[i] <= modEnableDly[i - 1];
		end
		// 8-bit wrap on the plain sum
		if (modEnableDly[depth - 1])
			channelSample <= carSample;
		else
			channelSample <= carSample + modSampleDly[depth - 1];
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < 2 * depth; i++)
				tagDly[i] <= '0;
			sampleTag <= '0;
		end
		else
		begin
			tagDly[0] <= stateTag;
			for (int i = 1; i < 2 * depth; i++)
				tagDly[i] <= tagDly[i - 1];
			sampleTag <= tagDly[2 * depth - 1];
		end
	end

endmodule

//--- fmRegBank.sv
`timescale 1ns/10ps

module fmRegBank (
	input logic clock,
	input logic reset,
	input fmSynthPkg::fmBusReq_t busReq,
	input fmSynthPkg::fmTag_t tag,
	input logic stepFrame,
	output fmSynthPkg::fmBusResp_t busResp,
	output fmSynthPkg::fmChanState_t chanState,
	output fmSynthPkg::fmTag_t stateTag
);

	fmSynthPkg::fmCtrlWord_t ctrlA [fmSynthPkg::fmNumChannels];
	fmSynthPkg::fmCtrlWord_t ctrlB [fmSynthPkg::fmNumChannels];
	fmSynthPkg::fmPhase_t phaseA [fmSynthPkg::fmNumChannels];
	fmSynthPkg::fmPhase_t phaseB [fmSynthPkg::fmNumChannels];

	fmSynthPkg::fmBusReq_t reqQ;
	logic stepQ;
	logic devSel;
	logic chanSel;
	logic readSel;
	logic writeSel;
	fmSynthPkg::fmChannel_t busChannel;
	logic [2:0] regOffset;
	fmSynthPkg::fmWord_t readMux;
	fmSynthPkg::fmPhase_t nextPhaseA;
	fmSynthPkg::fmPhase_t nextPhaseB;

	// decode works on the registered request
	assign devSel = (reqQ.addr[27:16] == fmSynthPkg::fmDevSelect);
	assign chanSel = (reqQ.addr[15:10] == fmSynthPkg::fmChanBlock);
	assign readSel = devSel && reqQ.opm[fmSynthPkg::fmOpmReadBit];
	assign writeSel = devSel && reqQ.opm[fmSynthPkg::fmOpmWriteBit];
	assign busChannel = reqQ.addr[8:5];
	assign regOffset = reqQ.addr[4:2];

	assign nextPhaseA = chanState.phaseA + chanState.ctrlA.increment;
	assign nextPhaseB = chanState.phaseB + chanState.ctrlB.increment;

	always_comb
	begin
		readMux = '0;
		if (readSel && chanSel)
		begin
			case (regOffset)
				fmSynthPkg::fmRegCtrlA: readMux = ctrlA[busChannel];
				fmSynthPkg::fmRegPhaseA: readMux = fmSynthPkg::fmWord_t'(phaseA[busChannel]);
				fmSynthPkg::fmRegCtrlB: readMux = ctrlB[busChannel];
				fmSynthPkg::fmRegPhaseB: readMux = fmSynthPkg::fmWord_t'(phaseB[busChannel]);
				// spare control words read as zero
				default: readMux = '0;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		reqQ <= busReq;
		if (reset)
			reqQ.opm <= '0;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			busResp.readData <= '0;
			busResp.ok <= fmSynthPkg::busOkReady;
			stateTag <= '0;
			stepQ <= 1'b0;
		end
		else
		begin
			busResp.readData <= readMux;
			busResp.ok <= (readSel || writeSel) ? fmSynthPkg::busOkOk : fmSynthPkg::busOkReady;
			stateTag <= tag;
			stepQ <= stepFrame;
		end
	end

	// state of the tagged channel, one cycle behind the tag
	always_ff @(posedge clock)
	begin
		chanState.ctrlA <= ctrlA[tag.channel];
		chanState.ctrlB <= ctrlB[tag.channel];
		chanState.phaseA <= phaseA[tag.channel];
		chanState.phaseB <= phaseB[tag.channel];
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < fmSynthPkg::fmNumChannels; i++)
			begin
				ctrlA[i] <= '0;
				ctrlB[i] <= '0;
				phaseA[i] <= '0;
				phaseB[i] <= '0;
			end
		end
		else
		begin
			if (writeSel && chanSel)
			begin
				case (regOffset)
					fmSynthPkg::fmRegCtrlA: ctrlA[busChannel] <= reqQ.writeData;
					fmSynthPkg::fmRegCtrlB: ctrlB[busChannel] <= reqQ.writeData;
					default:
					begin
						// phase registers only move by advance
					end
				endcase
			end
			// advance wraps at 20 bits
			if (stateTag.valid && stepQ)
			begin
				phaseA[stateTag.channel] <= nextPhaseA;
				phaseB[stateTag.channel] <= nextPhaseB;
			end
		end
	end

endmodule

//--- fmSynthPkg.sv
package fmSynthPkg;

	typedef logic [3:0] fmChannel_t;
	typedef logic [19:0] fmPhase_t;
	typedef logic signed [7:0] fmSample_t;
	typedef logic signed [11:0] fmAccum_t;
	typedef logic [31:0] fmWord_t;
	typedef logic [1:0] fmOk_t;
	typedef logic [4:0] fmOpm_t;

	// waveform codes, 8 to 15 fall back to sine
	typedef enum logic [3:0] {
		sine = 4'h0,
		halfSine = 4'h1,
		absSine = 4'h2,
		pulseSine = 4'h3,
		doubleHalf = 4'h4,
		doubleAbs = 4'h5,
		square = 4'h6,
		saw = 4'h7
	} fmWave_e;

	typedef struct packed {
		logic [3:0] wave;
		logic [2:0] shift;
		logic subHalf;
		logic subQuarter;
		logic subEighth;
		logic modEnable;
		logic reserved;
		fmPhase_t increment;
	} fmCtrlWord_t;

	typedef struct packed {
		fmWord_t addr;
		fmWord_t writeData;
		fmOpm_t opm;
	} fmBusReq_t;

	typedef struct packed {
		fmWord_t readData;
		fmOk_t ok;
	} fmBusResp_t;

	typedef struct packed {
		fmCtrlWord_t ctrlA;
		fmCtrlWord_t ctrlB;
		fmPhase_t phaseA;
		fmPhase_t phaseB;
	} fmChanState_t;

	typedef struct packed {
		fmChannel_t channel;
		logic valid;
	} fmTag_t;

	localparam int fmNumChannels = 16;
	localparam fmChannel_t fmLastChannel = 4'd15;

	localparam fmOk_t busOkReady = 2'b00;
	localparam fmOk_t busOkOk = 2'b01;
	localparam int fmOpmReadBit = 3;
	localparam int fmOpmWriteBit = 4;

	localparam logic [11:0] fmDevSelect = 12'h008;
	localparam logic [5:0] fmChanBlock = 6'b110000;
	localparam logic [2:0] fmRegCtrlA = 3'd0;
	localparam logic [2:0] fmRegPhaseA = 3'd3;
	localparam logic [2:0] fmRegCtrlB = 3'd4;
	localparam logic [2:0] fmRegPhaseB = 3'd7;

	// pipeline shape of one operator and where the modulator lands in the carrier phase
	localparam int fmShaperDepth = 3;
	localparam int fmModBit = 14;

	localparam fmSample_t sineTable [64] = '{
		8'h00, 8'h0C, 8'h18, 8'h24, 8'h30, 8'h3B, 8'h46, 8'h50,
		8'h59, 8'h62, 8'h69, 8'h70, 8'h75, 8'h79, 8'h7C, 8'h7E,
		8'h7F, 8'h7E, 8'h7C, 8'h79, 8'h75, 8'h70, 8'h69, 8'h62,
		8'h59, 8'h50, 8'h46, 8'h3B, 8'h30, 8'h24, 8'h18, 8'h0C,
		8'h00, 8'hF4, 8'hE8, 8'hDC, 8'hD0, 8'hC5, 8'hBA, 8'hB0,
		8'hA7, 8'h9E, 8'h97, 8'h90, 8'h8B, 8'h87, 8'h84, 8'h82,
		8'h81, 8'h82, 8'h84, 8'h87, 8'h8B, 8'h90, 8'h97, 8'h9E,
		8'hA7, 8'hB0, 8'hBA, 8'hC5, 8'hD0, 8'hDC, 8'hE8, 8'hF4
	};

endpackage

//--- fmSynthTb.sv
`timescale 1ns/10ps

module fmSynthTb;

	localparam int clockPeriod = 100;
	localparam int stimDelay = 10;
	localparam int resetCycles = 8;
	localparam int tickSpacing = 4;
	localparam int frameCycles = tickSpacing * fmSynthPkg::fmNumChannels;
	localparam int settleFrames = 4;
	localparam int outputTests = 8;
	// watchdog allows twice the summed cycle budgets of all tests
	localparam int outputTestCycles = resetCycles + 40 + settleFrames * frameCycles;
	localparam int readbackCycles = 200;
	localparam int advanceCycles = resetCycles + 40 + 9 * frameCycles;
	localparam int watchdogCycles =
		2 * (resetCycles + readbackCycles + outputTests * outputTestCycles + advanceCycles);

	// opcodes with only the read or the write bit set
	localparam fmSynthPkg::fmOpm_t readOpm = 5'b01000;
	localparam fmSynthPkg::fmOpm_t writeOpm = 5'b10000;
	// spare words first and the two phase registers last
	localparam logic [2:0] ignoredOffsets [6] = '{3'd1, 3'd2, 3'd5, 3'd6, 3'd3, 3'd7};
	localparam int squareLevel = 127;

	logic clock;
	logic reset;
	fmSynthPkg::fmBusReq_t busReq;
	logic channelTick;
	logic sampleTick;
	fmSynthPkg::fmBusResp_t busResp;
	fmSynthPkg::fmSample_t pcmLeft;
	fmSynthPkg::fmSample_t pcmRight;
	logic sampleEnable;
	int errorCount;
	int tickCount;

	fmSynthTop fmSynthTop_i (
		.clock(clock),
		.reset(reset),
		.busReq(busReq),
		.channelTick(channelTick),
		.sampleTick(sampleTick),
		.busResp(busResp),
		.pcmLeft(pcmLeft),
		.pcmRight(pcmRight)
	);

	always #(clockPeriod / 2) clock = ~clock;

	// channel tick every 4 cycles and sample tick once per frame when enabled
	initial
	begin
		tickCount = 0;
		forever
		begin
			@(posedge clock);
			#stimDelay;
			channelTick = (tickCount % tickSpacing) == 0;
			sampleTick = sampleEnable && ((tickCount % frameCycles) == 0);
			tickCount++;
		end
	end

	initial
	begin
		#(watchdogCycles * clockPeriod);
		abortRun("watchdog timeout, the tests did not finish in time");
	end

	task automatic abortRun(input string message);
		errorCount++;
		$display("%s", message);
		$display("Finished with errors");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic compareWord(input fmSynthPkg::fmWord_t actual,
			input fmSynthPkg::fmWord_t expected, input string what);
		if (actual !== expected)
			abortRun($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
				$time, what, actual, expected));
	endtask

	task automatic compareOk(input fmSynthPkg::fmOk_t actual,
			input fmSynthPkg::fmOk_t expected, input string what);
		if (actual !== expected)
			abortRun($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
				$time, what, actual, expected));
	endtask

	task automatic compareSample(input fmSynthPkg::fmSample_t actual,
			input fmSynthPkg::fmSample_t expected, input string what);
		if (actual !== expected)
			abortRun($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
				$time, what, actual, expected));
	endtask

	function automatic fmSynthPkg::fmWord_t regAddr(input fmSynthPkg::fmChannel_t channel,
			input logic [2:0] offset);
		return {4'h0, fmSynthPkg::fmDevSelect, fmSynthPkg::fmChanBlock, 1'b0, channel, offset,
			2'b00};
	endfunction

	// sub holds half, quarter and eighth from the top bit down
	function automatic fmSynthPkg::fmWord_t ctrlWord(input logic [3:0] wave,
			input logic [2:0] shift, input logic [2:0] sub, input logic modEnable,
			input logic [19:0] increment);
		fmSynthPkg::fmWord_t word;
		word = '0;
		word[31:28] = wave;
		word[27:25] = shift;
		word[24:22] = sub;
		word[21] = modEnable;
		word[19:0] = increment;
		return word;
	endfunction

	// saw climbs from -128 in steps of four with index bits 4:3 below
	function automatic int sawLevel(input int index);
		int steps;
		steps = index % 64;
		return (steps - 32) * 4 + (steps / 8) % 4;
	endfunction

	function automatic int wrapSample(input int value);
		return int'(fmSynthPkg::fmSample_t'(value));
	endfunction

	function automatic fmSynthPkg::fmSample_t mixExpected(input int total);
		if (total > 127)
			return 8'sh7F;
		else if (total < -128)
			return 8'sh80;
		else
			return fmSynthPkg::fmSample_t'(total);
	endfunction

	task automatic applyReset;
		@(posedge clock);
		#stimDelay;
		reset = 1'b1;
		repeat (resetCycles) @(posedge clock);
		#stimDelay;
		reset = 1'b0;
	endtask

	task automatic busWrite(input fmSynthPkg::fmWord_t addr, input fmSynthPkg::fmWord_t data);
		@(posedge clock);
		#stimDelay;
		busReq.addr = addr;
		busReq.writeData = data;
		busReq.opm = writeOpm;
		@(posedge clock);
		#stimDelay;
		busReq.opm = '0;
		@(posedge clock);
		#stimDelay;
		compareOk(busResp.ok, fmSynthPkg::busOkOk, "write response code");
	endtask

	task automatic busRead(input fmSynthPkg::fmWord_t addr, input fmSynthPkg::fmOk_t expectedOk,
			output fmSynthPkg::fmWord_t data);
		@(posedge clock);
		#stimDelay;
		busReq.addr = addr;
		busReq.writeData = '0;
		busReq.opm = readOpm;
		@(posedge clock);
		#stimDelay;
		busReq.opm = '0;
		// answer is registered twice
		@(posedge clock);
		#stimDelay;
		compareOk(busResp.ok, expectedOk, "read response code");
		data = busResp.readData;
	endtask

	task automatic setChannel(input fmSynthPkg::fmChannel_t channel,
			input fmSynthPkg::fmWord_t carrier, input fmSynthPkg::fmWord_t modulator);
		busWrite(regAddr(channel, fmSynthPkg::fmRegCtrlA), carrier);
		busWrite(regAddr(channel, fmSynthPkg::fmRegCtrlB), modulator);
	endtask

	task automatic checkMix(input int total, input string what);
		fmSynthPkg::fmSample_t expected;
		expected = mixExpected(total);
		repeat (settleFrames * frameCycles) @(posedge clock);
		#stimDelay;
		compareSample(pcmLeft, expected, {what, ", left"});
		compareSample(pcmRight, expected, {what, ", right"});
	endtask

	task automatic resetValues;
		compareSample(pcmLeft, 8'sh00, "left output after reset");
		compareSample(pcmRight, 8'sh00, "right output after reset");
		compareOk(busResp.ok, fmSynthPkg::busOkReady, "response code after reset");
		compareWord(busResp.readData, 32'h0, "read data after reset");
	endtask

	task automatic registerReadback;
		fmSynthPkg::fmChannel_t channel;
		fmSynthPkg::fmWord_t valueA;
		fmSynthPkg::fmWord_t valueB;
		fmSynthPkg::fmWord_t data;
		for (int n = 0; n < 6; n++)
		begin
			channel = fmSynthPkg::fmChannel_t'($urandom % 16);
			valueA = $urandom;
			valueB = $urandom;
			setChannel(channel, valueA, valueB);
			busRead(regAddr(channel, fmSynthPkg::fmRegCtrlA), fmSynthPkg::busOkOk, data);
			compareWord(data, valueA, "control A readback");
			busRead(regAddr(channel, fmSynthPkg::fmRegCtrlB), fmSynthPkg::busOkOk, data);
			compareWord(data, valueB, "control B readback");
		end
		channel = fmSynthPkg::fmChannel_t'($urandom % 16);
		for (int n = 0; n < 6; n++)
		begin
			busWrite(regAddr(channel, ignoredOffsets[n]), $urandom | 32'h1);
			busRead(regAddr(channel, ignoredOffsets[n]), fmSynthPkg::busOkOk, data);
			compareWord(data, 32'h0, $sformatf("register at offset %0d", ignoredOffsets[n]));
		end
		// device select 009 is someone else
		busRead(32'h0009_C000, fmSynthPkg::busOkReady, data);
		compareWord(data, 32'h0, "read data outside the device");
	endtask

	task automatic shiftedModulator;
		applyReset();
		setChannel(4'd3, ctrlWord(fmSynthPkg::square, 3'd0, 3'b000, 1'b0, 20'h0),
			ctrlWord(fmSynthPkg::square, 3'd7, 3'b000, 1'b0, 20'h0));
		checkMix(squareLevel + (squareLevel >> 7), "square with modulator shifted by 7");
	endtask

	task automatic silentCarrier;
		applyReset();
		// sine at phase 0 is silent
		setChannel(4'd9, ctrlWord(fmSynthPkg::sine, 3'd0, 3'b000, 1'b0, 20'h0),
			ctrlWord(fmSynthPkg::square, 3'd0, 3'b000, 1'b0, 20'h0));
		checkMix(0 + squareLevel, "silent carrier plus square modulator");
	endtask

	task automatic sawSaturation;
		applyReset();
		setChannel(4'd2, ctrlWord(fmSynthPkg::saw, 3'd0, 3'b000, 1'b0, 20'h0), 32'h0);
		setChannel(4'd11, ctrlWord(fmSynthPkg::saw, 3'd0, 3'b000, 1'b0, 20'h0), 32'h0);
		checkMix(2 * sawLevel(0), "two saw channels");
	endtask

	task automatic squareWrap;
		applyReset();
		setChannel(4'd6, ctrlWord(fmSynthPkg::square, 3'd0, 3'b000, 1'b0, 20'h0),
			ctrlWord(fmSynthPkg::square, 3'd0, 3'b000, 1'b0, 20'h0));
		checkMix(wrapSample(squareLevel + squareLevel), "square plus square wraps");
	endtask

	task automatic threeChannelClip;
		applyReset();
		setChannel(4'd0, ctrlWord(fmSynthPkg::square, 3'd0, 3'b000, 1'b0, 20'h0), 32'h0);
		setChannel(4'd7, ctrlWord(fmSynthPkg::square, 3'd0, 3'b000, 1'b0, 20'h0), 32'h0);
		setChannel(4'd15, ctrlWord(fmSynthPkg::square, 3'd0, 3'b000, 1'b0, 20'h0), 32'h0);
		checkMix(3 * squareLevel, "three full scale channels");
	endtask

	task automatic attenuateEighth;
		applyReset();
		setChannel(4'd12, ctrlWord(fmSynthPkg::square, 3'd0, 3'b001, 1'b0, 20'h0), 32'h0);
		checkMix(squareLevel - (squareLevel >> 3), "square less one eighth");
	endtask

	task automatic shiftByTwo;
		applyReset();
		setChannel(4'd12, ctrlWord(fmSynthPkg::square, 3'd2, 3'b000, 1'b0, 20'h0), 32'h0);
		checkMix(squareLevel >> 2, "square shifted by 2");
	endtask

	task automatic phaseModulation;
		applyReset();
		// modulator bits 7:2 become the carrier table index
		setChannel(4'd5, ctrlWord(fmSynthPkg::saw, 3'd0, 3'b000, 1'b1, 20'h0),
			ctrlWord(fmSynthPkg::square, 3'd0, 3'b000, 1'b0, 20'h0));
		checkMix(sawLevel(squareLevel >> 2), "saw carrier moved by square modulator");
	endtask

	task automatic phaseAdvance;
		fmSynthPkg::fmWord_t first;
		fmSynthPkg::fmWord_t second;
		applyReset();
		sampleEnable = 1'b1;
		setChannel(4'd5, ctrlWord(fmSynthPkg::sine, 3'd0, 3'b000, 1'b0, 20'h100), 32'h0);
		repeat (6 * frameCycles) @(posedge clock);
		busRead(regAddr(4'd5, fmSynthPkg::fmRegPhaseA), fmSynthPkg::busOkOk, first);
		compareWord(first & 32'hFFF0_0000, 32'h0, "phase A upper bits");
		compareWord(first & 32'h0000_00FF, 32'h0, "phase A below the increment");
		if (first == 32'h0)
			abortRun("phase A of channel 5 did not advance with sample ticks running");
		repeat (3 * frameCycles) @(posedge clock);
		busRead(regAddr(4'd5, fmSynthPkg::fmRegPhaseA), fmSynthPkg::busOkOk, second);
		compareWord(second & 32'h0000_00FF, 32'h0, "phase A below the increment");
		if (second <= first)
			abortRun("phase A of channel 5 did not grow between two reads");
		sampleEnable = 1'b0;
	endtask

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		busReq = '0;
		channelTick = 1'b0;
		sampleTick = 1'b0;
		sampleEnable = 1'b0;
		errorCount = 0;
		void'($urandom(74));
		applyReset();
		resetValues();
		registerReadback();
		shiftedModulator();
		silentCarrier();
		sawSaturation();
		squareWrap();
		threeChannelClip();
		attenuateEighth();
		shiftByTwo();
		phaseModulation();
		phaseAdvance();
		if (errorCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- fmSynthTop.sv
`timescale 1ns/10ps

module fmSynthTop (
	input logic clock,
	input logic reset,
	input fmSynthPkg::fmBusReq_t busReq,
	input logic channelTick,
	input logic sampleTick,
	output fmSynthPkg::fmBusResp_t busResp,
	output fmSynthPkg::fmSample_t pcmLeft,
	output fmSynthPkg::fmSample_t pcmRight
);

	fmSynthPkg::fmTag_t tag;
	logic stepFrame;
	logic frameEnd;
	fmSynthPkg::fmChanState_t chanState;
	fmSynthPkg::fmTag_t stateTag;
	fmSynthPkg::fmSample_t channelSample;
	fmSynthPkg::fmTag_t sampleTag;

	fmChannelScheduler fmChannelScheduler_i (
		.clock(clock),
		.reset(reset),
		.channelTick(channelTick),
		.sampleTick(sampleTick),
		.tag(tag),
		.stepFrame(stepFrame),
		.frameEnd(frameEnd)
	);

	fmRegBank fmRegBank_i (
		.clock(clock),
		.reset(reset),
		.busReq(busReq),
		.tag(tag),
		.stepFrame(stepFrame),
		.busResp(busResp),
		.chanState(chanState),
		.stateTag(stateTag)
	);

	fmOperatorPair fmOperatorPair_i (
		.clock(clock),
		.reset(reset),
		.chanState(chanState),
		.stateTag(stateTag),
		.channelSample(channelSample),
		.sampleTag(sampleTag)
	);

	fmMixer fmMixer_i (
		.clock(clock),
		.reset(reset),
		.channelSample(channelSample),
		.sampleTag(sampleTag),
		.frameEnd(frameEnd),
		.pcmLeft(pcmLeft),
		.pcmRight(pcmRight)
	);

endmodule

//--- fmWaveShaper.sv
`timescale 1ns/10ps

module fmWaveShaper (
	input logic clock,
	input logic reset,
	input fmSynthPkg::fmPhase_t phase,
	input fmSynthPkg::fmCtrlWord_t ctrl,
	output fmSynthPkg::fmSample_t sample
);

	// stage 1
	fmSynthPkg::fmSample_t tabMain;
	fmSynthPkg::fmSample_t tabDouble;
	logic [5:0] index1;
	logic halfCycle1;
	fmSynthPkg::fmCtrlWord_t ctrl1;

	// stage 2
	fmSynthPkg::fmSample_t shaped;
	fmSynthPkg::fmSample_t attenuated;
	fmSynthPkg::fmSample_t level2;
	logic [2:0] shift2;

	// table lookups at normal and double rate
	always_ff @(posedge clock)
	begin
		tabMain <= fmSynthPkg::sineTable[phase[19:14]];
		tabDouble <= fmSynthPkg::sineTable[phase[18:13]];
		index1 <= phase[19:14];
		halfCycle1 <= phase[18];
		ctrl1 <= ctrl;
	end

	always_comb
	begin
		case (ctrl1.wave)
			fmSynthPkg::halfSine: shaped = tabMain[7] ? 8'sh00 : tabMain;
			fmSynthPkg::absSine: shaped = tabMain[7] ? ~tabMain : tabMain;
			fmSynthPkg::pulseSine: shaped = halfCycle1 ? 8'sh00 : tabMain;
			fmSynthPkg::doubleHalf: shaped = halfCycle1 ? 8'sh00 : tabDouble;
			fmSynthPkg::doubleAbs:
			begin
				if (halfCycle1)
					shaped = 8'sh00;
				else
					shaped = tabDouble[7] ? ~tabDouble : tabDouble;
			end
			fmSynthPkg::square: shaped = tabMain[7] ? 8'sh80 : 8'sh7F;
			// ramp straight from the index
			fmSynthPkg::saw: shaped = {~index1[5], index1[4:0], index1[4:3]};
			default: shaped = tabMain;
		endcase

		// each enabled bit takes off a fraction of the shaped value
		attenuated = shaped;
		if (ctrl1.subEighth)
			attenuated = attenuated - (shaped >> 3);
		if (ctrl1.subQuarter)
			attenuated = attenuated - (shaped >> 2);
		if (ctrl1.subHalf)
			attenuated = attenuated - (shaped >> 1);
	end

	always_ff @(posedge clock)
	begin
		level2 <= attenuated;
		shift2 <= ctrl1.shift;
		// logical shift, sign is not kept
		if (reset)
			sample <= '0;
		else
			sample <= level2 >> shift2;
	end

endmodule

//--- runSim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and search the log for the fail message
verilator --binary --timing --timescale 1ns/10ps --top-module fmSynthTb \
	-f filelist.f --Mdir obj_dir -o fmSynthSim > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/fmSynthSim > sim.log 2>&1
cat sim.log
grep -q "Finished with errors" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Finished with no errors" sim.log && { echo "simulation passed"; exit 0; } \
	|| { echo "simulation ended without a result"; exit 1; }
